//--- Bender.yml
package:
  name: apb_uart

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uartPkg.sv
      - rtl/uartRegs.sv
      - rtl/uartBaudGen.sv
      - rtl/uartFifo.sv
      - rtl/uartTx.sv
      - rtl/uartRx.sv
      - rtl/apbUart.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/uartChecker.sv
      - verification/uartTb.sv

//--- all.f
+incdir+rtl
rtl/uartPkg.sv
rtl/uartRegs.sv
rtl/uartBaudGen.sv
rtl/uartFifo.sv
rtl/uartTx.sv
rtl/uartRx.sv
rtl/apbUart.sv
verification/uartChecker.sv
verification/uartTb.sv

//--- rtl/apbUart.sv
// APB-attached 16550-style UART, top level
// Connects the register block, baud generator, TX and RX FIFOs and the
// serial engines. Loopback feeds the transmitter output to the receiver
// and holds SOUT at mark
`timescale 1ns/10ps
`include "uart_config.svh"

module apbUart
(
	input  logic CLK,
	input  logic iRST,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`UART_ADDR_W-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic sin,
	output logic sout
);
	logic txPushValid;
	logic txPushReady;
	logic txPopValid;
	logic txPopReady;
	logic txEmpty;
	logic txBusy;
	logic txd;
	logic rxd;
	logic rxPushValid;
	logic rxPushReady;
	logic rxPopValid;
	logic rxPopReady;
	logic rxOverrun;
	logic tick16;
	logic twoStop;
	logic breakCtl;
	logic loopback;
	logic [`UART_DIV_W-1:0] divisor;
	uartPkg::byteT txPushData;
	uartPkg::byteT txPopData;
	uartPkg::rxCharT rxPushData;
	uartPkg::rxCharT rxPopData;
	uartPkg::wordLenE wordLen;
	uartPkg::parityModeE parityMode;

	// Zero-wait slave without error responses
	assign pready = 1'b1;
	assign pslverr = 1'b0;

	uartRegs regs (.*);

	uartBaudGen baudGen (.*);

	uartFifo #(.PAYLOAD_T(uartPkg::byteT)) txFifo (.CLK, .iRST,
		.pushValid(txPushValid), .pushData(txPushData), .pushReady(txPushReady),
		.popValid(txPopValid), .popData(txPopData), .popReady(txPopReady),
		.empty(txEmpty));

	uartFifo #(.PAYLOAD_T(uartPkg::rxCharT)) rxFifo (.CLK, .iRST,
		.pushValid(rxPushValid), .pushData(rxPushData), .pushReady(rxPushReady),
		.popValid(rxPopValid), .popData(rxPopData), .popReady(rxPopReady),
		.empty());

	uartTx tx (.*, .popValid(txPopValid), .popData(txPopData), .popReady(txPopReady));

	uartRx rx (.*, .pushValid(rxPushValid), .pushData(rxPushData), .pushReady(rxPushReady));

	assign rxd = loopback ? txd : sin;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
			sout <= 1'b1;
		else
			sout <= loopback || txd;
	end

endmodule

//--- rtl/uartBaudGen.sv
// Baud rate generator
// Divides CLK by the 16-bit divisor into a one-cycle tick16 pulse,
// which runs at UART_OVERSAMPLE times the bit rate. A zero divisor stops it
`timescale 1ns/10ps
`include "uart_config.svh"

module uartBaudGen
(
	input  logic CLK,
	input  logic iRST,
	input  logic [`UART_DIV_W-1:0] divisor,
	output logic tick16
);
	logic [`UART_DIV_W-1:0] count;
	logic [`UART_DIV_W-1:0] lastDivisor;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			count <= '0;
			lastDivisor <= '0;
			tick16 <= 1'b0;
		end
		else
		begin
			lastDivisor <= divisor;
			tick16 <= 1'b0;
			// New divisor value restarts the count
			if (divisor != lastDivisor)
				count <= divisor;
			else if (divisor != '0)
			begin
				if (count <= `UART_DIV_W'(1))
				begin
					count <= divisor;
					tick16 <= 1'b1;
				end
				else
					count <= count - 1'b1;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (iRST)
		(tick16 && divisor > `UART_DIV_W'(1)) |=> !tick16);

endmodule

//--- rtl/uartFifo.sv
// Synchronous FIFO between the register block and a serial engine
// Circular buffer of UART_FIFO_DEPTH entries with an occupancy count.
// The payload type is set per instance: characters on the TX side,
// tagged characters on the RX side. Both ports use valid/ready
`timescale 1ns/10ps
`include "uart_config.svh"

module uartFifo
#(
	parameter type PAYLOAD_T = uartPkg::byteT
)
(
	input  logic CLK,
	input  logic iRST,
	input  logic pushValid,
	input  PAYLOAD_T pushData,
	output logic pushReady,
	output logic popValid,
	output PAYLOAD_T popData,
	input  logic popReady,
	output logic empty
);
	localparam int DEPTH = `UART_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	PAYLOAD_T mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0] count;
	logic doPush;
	logic doPop;

	assign empty = (count == '0);
	assign pushReady = (count != (PTR_W + 1)'(DEPTH));
	assign popValid = !empty;
	assign popData = mem[rdPtr];
	assign doPush = pushValid && pushReady;
	assign doPop = popValid && popReady;

	always_ff @(posedge CLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	assert property (@(posedge CLK) disable iff (iRST) count <= (PTR_W + 1)'(DEPTH));

endmodule

//--- rtl/uartPkg.sv
// Shared types of the APB UART
// Referenced by scoped name from the register block, the FIFOs and
// both serial engines
`include "uart_config.svh"

package uartPkg;

	// One character as held in the TX FIFO and returned by RBR
	typedef logic [`UART_DATA_W-1:0] byteT;

	// Received character tagged with its line errors
	typedef struct packed {
		logic bi;
		logic fe;
		logic pe;
		byteT data;
	} rxCharT;

	// LCR[1:0] word length code
	typedef enum logic [1:0] {WORD5, WORD6, WORD7, WORD8} wordLenE;

	// Parity mode decoded from LCR PEN, EPS and stick parity
	typedef enum logic [2:0] {PAR_NONE, PAR_ODD, PAR_EVEN, PAR_ONE, PAR_ZERO} parityModeE;

endpackage

//--- rtl/uartRegs.sv
// Register block of the APB UART
// Decodes zero-wait APB accesses with DLAB banking at offsets 0 and 1,
// holds LCR, DLL, DLM, MCR loopback and SCR, and keeps the LSR flags.
// THR writes push the TX FIFO and RBR reads pop the RX FIFO directly
`timescale 1ns/10ps
`include "uart_config.svh"

module uartRegs
(
	input  logic CLK,
	input  logic iRST,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`UART_ADDR_W-1:0] paddr,
	input  logic [31:0] pwdata,
	input  logic txPushReady,
	input  logic rxPopValid,
	input  uartPkg::rxCharT rxPopData,
	input  logic rxOverrun,
	input  logic txBusy,
	input  logic txEmpty,
	output logic [31:0] prdata,
	output logic txPushValid,
	output uartPkg::byteT txPushData,
	output logic rxPopReady,
	output logic [`UART_DIV_W-1:0] divisor,
	output uartPkg::wordLenE wordLen,
	output uartPkg::parityModeE parityMode,
	output logic twoStop,
	output logic breakCtl,
	output logic loopback
);
	logic apbWrite;
	logic apbRead;
	logic dlab;
	logic lsrRead;
	logic headSeen;
	logic headCapture;
	logic lsrOe;
	logic lsrPe;
	logic lsrFe;
	logic lsrBi;
	uartPkg::byteT lcr;
	uartPkg::byteT dll;
	uartPkg::byteT dlm;
	uartPkg::byteT scr;
	uartPkg::byteT lsr;
	uartPkg::byteT readByte;

	assign apbWrite = psel && penable && pwrite;
	assign apbRead = psel && penable && !pwrite;
	assign dlab = lcr[7];
	assign lsrRead = apbRead && (paddr == `UART_ADDR_LSR);

	// A full TX FIFO ignores the THR write
	assign txPushValid = apbWrite && (paddr == `UART_ADDR_RBR_THR) && !dlab && txPushReady;
	assign txPushData = pwdata[`UART_DATA_W-1:0];
	assign rxPopReady = apbRead && (paddr == `UART_ADDR_RBR_THR) && !dlab && rxPopValid;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			lcr <= '0;
			dll <= '0;
			dlm <= '0;
			scr <= '0;
			loopback <= 1'b0;
		end
		else if (apbWrite)
		begin
			case (paddr)
				`UART_ADDR_RBR_THR:
				begin
					if (dlab)
						dll <= pwdata[`UART_DATA_W-1:0];
				end
				`UART_ADDR_DLM:
				begin
					if (dlab)
						dlm <= pwdata[`UART_DATA_W-1:0];
				end
				`UART_ADDR_LCR: lcr <= pwdata[`UART_DATA_W-1:0];
				`UART_ADDR_MCR: loopback <= pwdata[4];
				`UART_ADDR_SCR: scr <= pwdata[`UART_DATA_W-1:0];
				default: ;
			endcase
		end
	end

	// Error flags of a character are taken once, when it becomes the FIFO head
	assign headCapture = rxPopValid && !headSeen;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			headSeen <= 1'b0;
			lsrOe <= 1'b0;
			lsrPe <= 1'b0;
			lsrFe <= 1'b0;
			lsrBi <= 1'b0;
		end
		else
		begin
			if (rxPopReady)
				headSeen <= 1'b0;
			else if (rxPopValid)
				headSeen <= 1'b1;
			// Setting wins over the clear by an LSR read
			lsrOe <= rxOverrun || (lsrOe && !lsrRead);
			lsrPe <= (headCapture && rxPopData.pe) || (lsrPe && !lsrRead);
			lsrFe <= (headCapture && rxPopData.fe) || (lsrFe && !lsrRead);
			lsrBi <= (headCapture && rxPopData.bi) || (lsrBi && !lsrRead);
		end
	end

	assign lsr = {1'b0, txEmpty && !txBusy, txEmpty, lsrBi, lsrFe, lsrPe, lsrOe, rxPopValid};

	// Frame settings to the engines
	assign divisor = {dlm, dll};
	assign wordLen = uartPkg::wordLenE'(lcr[1:0]);
	assign twoStop = lcr[2];
	assign breakCtl = lcr[6];

	always_comb
	begin
		if (!lcr[3])
			parityMode = uartPkg::PAR_NONE;
		else
		begin
			// EPS selects even, stick parity sends the inverse of EPS
			case (lcr[5:4])
				2'b00: parityMode = uartPkg::PAR_ODD;
				2'b01: parityMode = uartPkg::PAR_EVEN;
				2'b10: parityMode = uartPkg::PAR_ONE;
				default: parityMode = uartPkg::PAR_ZERO;
			endcase
		end
	end

	always_comb
	begin
		readByte = '0;
		case (paddr)
			`UART_ADDR_RBR_THR: readByte = dlab ? dll : rxPopData.data;
			`UART_ADDR_DLM: readByte = dlab ? dlm : '0;
			`UART_ADDR_LCR: readByte = lcr;
			`UART_ADDR_MCR: readByte = {3'b000, loopback, 4'b0000};
			`UART_ADDR_LSR: readByte = lsr;
			`UART_ADDR_SCR: readByte = scr;
			default: readByte = '0;
		endcase
	end

	assign prdata = {{(32 - `UART_DATA_W){1'b0}}, readByte};

	// Pops only reach the RX FIFO while it holds a character
	assert property (@(posedge CLK) disable iff (iRST) rxPopReady |-> rxPopValid);

endmodule

//--- rtl/uartRx.sv
// Receive engine
// Synchronizes the serial input, starts a frame on a falling edge and
// samples every bit at mid-bit on the tick count. At the middle of the
// first stop bit it pushes the character with its PE, FE and BI flags,
// or pulses rxOverrun when the RX FIFO has no room
`timescale 1ns/10ps
`include "uart_config.svh"

module uartRx
(
	input  logic CLK,
	input  logic iRST,
	input  logic tick16,
	input  logic rxd,
	input  uartPkg::wordLenE wordLen,
	input  uartPkg::parityModeE parityMode,
	input  logic twoStop,
	input  logic pushReady,
	output logic pushValid,
	output uartPkg::rxCharT pushData,
	output logic rxOverrun
);
	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);

	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rxStateE;

	rxStateE state;
	logic rxMeta;
	logic rxSync;
	logic rxLast;
	logic [TICK_W-1:0] tickCnt;
	logic [2:0] bitCnt;
	logic [3:0] dataBits;
	logic midStart;
	logic midBit;
	logic frameEnd;
	logic parityAcc;
	logic parityBad;
	logic parityErr;
	logic allZero;
	uartPkg::byteT shiftReg;

	assign dataBits = 4'd5 + {2'b00, wordLen};
	assign midStart = tick16 && (tickCnt == TICK_W'(`UART_OVERSAMPLE / 2 - 1));
	assign midBit = tick16 && (tickCnt == TICK_W'(`UART_OVERSAMPLE - 1));
	assign frameEnd = (state == RX_STOP) && midBit && (bitCnt == '0);

	// Parity check of the sampled parity bit against the data bits
	always_comb
	begin
		case (parityMode)
			uartPkg::PAR_ODD: parityBad = !(parityAcc ^ rxSync);
			uartPkg::PAR_EVEN: parityBad = parityAcc ^ rxSync;
			uartPkg::PAR_ONE: parityBad = !rxSync;
			uartPkg::PAR_ZERO: parityBad = rxSync;
			default: parityBad = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxLast <= 1'b1;
			state <= RX_IDLE;
			tickCnt <= '0;
			bitCnt <= '0;
			parityAcc <= 1'b0;
			parityErr <= 1'b0;
			allZero <= 1'b0;
			pushValid <= 1'b0;
			rxOverrun <= 1'b0;
		end
		else
		begin
			rxMeta <= rxd;
			rxSync <= rxMeta;
			rxLast <= rxSync;
			pushValid <= frameEnd && pushReady;
			rxOverrun <= frameEnd && !pushReady;
			if (state == RX_IDLE || (state == RX_START && midStart))
				tickCnt <= '0;
			else if (tick16)
				tickCnt <= tickCnt + 1'b1;
			case (state)
				RX_IDLE:
				begin
					if (rxLast && !rxSync)
						state <= RX_START;
				end
				RX_START:
				begin
					// Back to idle if the line is high again at mid start bit
					if (midStart && rxSync)
						state <= RX_IDLE;
					else if (midStart)
					begin
						state <= RX_DATA;
						bitCnt <= '0;
						parityAcc <= 1'b0;
						parityErr <= 1'b0;
						allZero <= 1'b1;
					end
				end
				RX_DATA:
				begin
					if (midBit)
					begin
						parityAcc <= parityAcc ^ rxSync;
						allZero <= allZero && !rxSync;
						bitCnt <= bitCnt + 1'b1;
						if ({1'b0, bitCnt} == dataBits - 4'd1)
						begin
							bitCnt <= '0;
							if (parityMode == uartPkg::PAR_NONE)
								state <= RX_STOP;
							else
								state <= RX_PARITY;
						end
					end
				end
				RX_PARITY:
				begin
					if (midBit)
					begin
						parityErr <= parityBad;
						allZero <= allZero && !rxSync;
						state <= RX_STOP;
					end
				end
				RX_STOP:
				begin
					// Second stop bit is waited out but not checked
					if (frameEnd && twoStop)
						bitCnt <= 3'd1;
					else if (midBit)
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == RX_DATA && midBit)
			shiftReg <= {rxSync, shiftReg[`UART_DATA_W-1:1]};
		if (frameEnd)
		begin
			pushData.data <= shiftReg >> (4'd8 - dataBits);
			pushData.pe <= parityErr;
			pushData.fe <= !rxSync;
			pushData.bi <= allZero && !rxSync;
		end
	end

	// Push is only issued when the RX FIFO had room at frame end
	assert property (@(posedge CLK) disable iff (iRST) pushValid |-> pushReady);

endmodule

//--- rtl/uartTx.sv
// Transmit engine
// Pops a character from the TX FIFO on a baud tick and shifts out
// start, 5 to 8 data bits LSB first, optional parity and 1 or 2 stop bits.
// Every bit lasts UART_OVERSAMPLE ticks. breakCtl holds the line low
`timescale 1ns/10ps
`include "uart_config.svh"

module uartTx
(
	input  logic CLK,
	input  logic iRST,
	input  logic tick16,
	input  uartPkg::wordLenE wordLen,
	input  uartPkg::parityModeE parityMode,
	input  logic twoStop,
	input  logic breakCtl,
	input  logic popValid,
	input  uartPkg::byteT popData,
	output logic popReady,
	output logic txd,
	output logic txBusy
);
	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);

	typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} txStateE;

	txStateE state;
	logic [TICK_W-1:0] tickCnt;
	logic [2:0] bitCnt;
	logic [3:0] dataBits;
	logic bitDone;
	logic parityBit;
	logic nextParity;
	logic lineBit;
	uartPkg::byteT dataMask;
	uartPkg::byteT shiftReg;

	assign dataBits = 4'd5 + {2'b00, wordLen};
	assign dataMask = 8'hff >> (4'd8 - dataBits);

	// Frames start on a tick so the start bit is a full bit long
	assign popReady = (state == TX_IDLE) && tick16;
	assign txBusy = (state != TX_IDLE);
	assign bitDone = tick16 && (tickCnt == TICK_W'(`UART_OVERSAMPLE - 1));

	always_comb
	begin
		case (parityMode)
			uartPkg::PAR_ODD: nextParity = ~^(popData & dataMask);
			uartPkg::PAR_EVEN: nextParity = ^(popData & dataMask);
			uartPkg::PAR_ZERO: nextParity = 1'b0;
			default: nextParity = 1'b1;
		endcase
	end

	always_comb
	begin
		case (state)
			TX_START: lineBit = 1'b0;
			TX_DATA: lineBit = shiftReg[0];
			TX_PARITY: lineBit = parityBit;
			default: lineBit = 1'b1;
		endcase
	end

	assign txd = lineBit && !breakCtl;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= TX_IDLE;
			tickCnt <= '0;
			bitCnt <= '0;
		end
		else
		begin
			if (state == TX_IDLE)
				tickCnt <= '0;
			else if (tick16)
				tickCnt <= tickCnt + 1'b1;
			case (state)
				TX_IDLE:
				begin
					if (popValid && popReady)
						state <= TX_START;
				end
				TX_START:
				begin
					if (bitDone)
					begin
						state <= TX_DATA;
						bitCnt <= '0;
					end
				end
				TX_DATA:
				begin
					if (bitDone)
					begin
						bitCnt <= bitCnt + 1'b1;
						if ({1'b0, bitCnt} == dataBits - 4'd1)
						begin
							bitCnt <= '0;
							if (parityMode == uartPkg::PAR_NONE)
								state <= TX_STOP;
							else
								state <= TX_PARITY;
						end
					end
				end
				TX_PARITY:
				begin
					if (bitDone)
						state <= TX_STOP;
				end
				TX_STOP:
				begin
					if (bitDone)
					begin
						if (twoStop && bitCnt == '0)
							bitCnt <= 3'd1;
						else
							state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (popValid && popReady)
		begin
			shiftReg <= popData & dataMask;
			parityBit <= nextParity;
		end
		else if (state == TX_DATA && bitDone)
			shiftReg <= shiftReg >> 1;
	end

	// Idle line is at mark unless a break is requested
	assert property (@(posedge CLK) disable iff (iRST)
		(state == TX_IDLE && !breakCtl) |-> txd);

endmodule

//--- rtl/uart_config.svh
// Build constants for the APB UART
// Character and register address widths, FIFO depth, the oversampling
// ratio of the baud tick and the register map
// Include wherever one of these values is needed
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Character width and the part of the APB data bus in use
`define UART_DATA_W 8
`define UART_ADDR_W 3
`define UART_FIFO_DEPTH 16
// Baud ticks per serial bit
`define UART_OVERSAMPLE 16
`define UART_DIV_W 16

// Register offsets
`define UART_ADDR_RBR_THR 3'd0
// Offset 1 holds DLM while DLAB is set and reads zero otherwise
`define UART_ADDR_DLM 3'd1
`define UART_ADDR_LCR 3'd3
`define UART_ADDR_MCR 3'd4
`define UART_ADDR_LSR 3'd5
`define UART_ADDR_SCR 3'd7

`endif

//--- verification/uartChecker.sv
// Checker of the APB UART testbench
// Watches the APB and serial ports of the DUT, tracks LCR, divisor and
// loopback from APB writes, compares queued read expectations and every
// frame on sout against the reference functions, and counts errors
`timescale 1ns/10ps
`include "uart_config.svh"

module uartChecker
(
	input logic CLK,
	input logic iRST,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`UART_ADDR_W-1:0] paddr,
	input logic [31:0] pwdata,
	input logic [31:0] prdata,
	input logic pready,
	input logic pslverr,
	input logic sout
);
	int errors = 0;
	int checks = 0;
	logic [7:0] lcr = 8'h00;
	logic [7:0] dll = 8'h00;
	logic [7:0] dlm = 8'h00;
	logic loopback = 1'b0;
	logic frameBusy = 1'b0;
	logic [7:0] txExp[$];
	string expName[$];
	logic [7:0] expVal[$];
	logic [7:0] expMask[$];
	logic [7:0] readMask;

	// Parity bit for the data bits selected by LCR
	function automatic logic parityRef(input logic [7:0] d, input logic [7:0] l);
		int i;
		logic p;
		p = 1'b0;
		for (i = 0; i < 5 + int'(l[1:0]); i++)
			p = p ^ d[i];
		if (l[5])
			return !l[4];
		return l[4] ? p : !p;
	endfunction

	function automatic int frameLen(input logic [7:0] l);
		return 7 + int'(l[1:0]) + int'(l[3]) + int'(l[2]);
	endfunction

	// Line bits in send order, start bit at index 0
	function automatic logic [11:0] frameRef(input logic [7:0] d, input logic [7:0] l);
		logic [11:0] f;
		int i;
		int n;
		f = '1;
		f[0] = 1'b0;
		n = 5 + int'(l[1:0]);
		for (i = 0; i < n; i++)
			f[1 + i] = d[i];
		if (l[3])
			f[1 + n] = parityRef(d, l);
		return f;
	endfunction

	function automatic logic [7:0] lsrRef(input logic dr, oe, pe, fe, bi, thre, temt);
		return {1'b0, temt, thre, bi, fe, pe, oe, dr};
	endfunction

	function automatic int pendingTx();
		return txExp.size() + int'(frameBusy);
	endfunction

	function automatic int pendingReads();
		return expVal.size();
	endfunction

	task automatic expectRead(input string name, input logic [7:0] v, input logic [7:0] m);
		expName.push_back(name);
		expVal.push_back(v);
		expMask.push_back(m);
	endtask

	task automatic compareValue(input string name, input logic [11:0] exp, input logic [11:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("ERROR %s: expected 0x%h, actual 0x%h", name, exp, act);
		end
	endtask

	// APB accesses are stable at the falling edge of the access phase
	always @(negedge CLK)
	begin
		if (iRST)
		begin
			lcr = 8'h00;
			dll = 8'h00;
			dlm = 8'h00;
			loopback = 1'b0;
		end
		else if (psel && penable && pready && pwrite)
		begin
			case (paddr)
				`UART_ADDR_RBR_THR:
				begin
					if (lcr[7])
						dll = pwdata[7:0];
					else if (!loopback)
						txExp.push_back(pwdata[7:0]);
				end
				`UART_ADDR_DLM:
				begin
					if (lcr[7])
						dlm = pwdata[7:0];
				end
				`UART_ADDR_LCR: lcr = pwdata[7:0];
				`UART_ADDR_MCR: loopback = pwdata[4];
				default: ;
			endcase
		end
		else if (psel && penable && pready && expVal.size() > 0)
		begin
			readMask = expMask.pop_front();
			compareValue(expName.pop_front(), expVal.pop_front() & readMask,
				prdata[7:0] & readMask);
		end
		// Every access phase answers without an error response
		if (!iRST && psel && penable)
			compareValue("PSLVERR", 12'h000, {11'd0, pslverr});
		if (!iRST && loopback && sout !== 1'b1)
		begin
			errors++;
			$display("sout left the mark level while loopback was set");
		end
	end

	// Samples each frame on sout at mid-bit
	initial
	begin
		logic [11:0] want;
		logic [11:0] got;
		logic [11:0] mask;
		logic [7:0] d;
		logic [7:0] fl;
		int len;
		int bitClocks;
		int i;
		forever
		begin
			@(negedge sout);
			if (iRST !== 1'b0 || loopback)
				continue;
			if (txExp.size() == 0)
			begin
				errors++;
				$display("A frame started on sout with no byte written to THR");
				continue;
			end
			d = txExp.pop_front();
			frameBusy = 1'b1;
			fl = lcr;
			bitClocks = int'({dlm, dll}) * `UART_OVERSAMPLE;
			len = frameLen(fl);
			want = frameRef(d, fl);
			got = '1;
			repeat (bitClocks / 2) @(posedge CLK);
			got[0] = sout;
			for (i = 1; i < len; i++)
			begin
				repeat (bitClocks) @(posedge CLK);
				got[i] = sout;
			end
			mask = 12'hfff >> (12 - len);
			compareValue("transmit frame", want & mask, got & mask);
			frameBusy = 1'b0;
		end
	end

endmodule

//--- verification/uartTb.sv
// Testbench top of the APB UART
// Generates clock and reset, drives APB accesses and serial frames on sin,
// and runs reset, register, transmit, loopback, receive error and overrun
// tests. uartChecker does the comparing
`timescale 1ns/10ps
`include "uart_config.svh"

module uartTb;
	logic CLK = 1'b0;
	logic iRST = 1'b1;
	logic psel = 1'b0;
	logic penable = 1'b0;
	logic pwrite = 1'b0;
	logic [`UART_ADDR_W-1:0] paddr = '0;
	logic [31:0] pwdata = '0;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic sin = 1'b1;
	logic sout;
	logic [31:0] lfsr = 32'h63cfe42b;
	int divisor = 2;

	always #10 CLK = !CLK;

	apbUart dut (.*);

	uartChecker chk (.CLK, .iRST, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
		.pready, .pslverr, .sout);

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic randByte(output logic [7:0] v);
		int i;
		for (i = 0; i < 8; i++)
		begin
			lfsr = lfsrNext(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	// Setup phase, then access phase until PREADY
	task automatic apbAccess(input logic wr, input logic [2:0] a, input logic [7:0] d,
		output logic [7:0] rd);
		int n;
		@(posedge CLK);
		#1;
		psel = 1'b1;
		pwrite = wr;
		paddr = a;
		pwdata = {24'd0, d};
		penable = 1'b0;
		@(posedge CLK);
		#1;
		penable = 1'b1;
		n = 0;
		@(negedge CLK);
		while (!pready)
		begin
			n++;
			if (n > 16)
				abortRun("APB access got no PREADY");
			@(negedge CLK);
		end
		rd = prdata[7:0];
		@(posedge CLK);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbWrite(input logic [2:0] a, input logic [7:0] d);
		logic [7:0] unused;
		apbAccess(1'b1, a, d, unused);
	endtask

	task automatic apbRead(input logic [2:0] a, output logic [7:0] d);
		apbAccess(1'b0, a, 8'h00, d);
	endtask

	task automatic checkRead(input string name, input logic [2:0] a, input logic [7:0] v,
		input logic [7:0] m);
		logic [7:0] d;
		chk.expectRead(name, v, m);
		apbRead(a, d);
	endtask

	// Polls LSR until any bit of the mask is set
	task automatic waitLsr(input logic [7:0] mask);
		logic [7:0] d;
		int n;
		n = 0;
		apbRead(`UART_ADDR_LSR, d);
		while ((d & mask) == 8'h00)
		begin
			n++;
			if (n > 4000)
				abortRun("Timed out waiting for a line status bit");
			apbRead(`UART_ADDR_LSR, d);
		end
	endtask

	task automatic waitTxDone();
		int n;
		n = 0;
		while (chk.pendingTx() != 0)
		begin
			n++;
			if (n > 40000)
				abortRun("Timed out waiting for transmit frames on sout");
			@(posedge CLK);
		end
		waitLsr(8'h40);
	endtask

	task automatic setDivisor(input logic [7:0] l);
		apbWrite(`UART_ADDR_LCR, 8'h80);
		apbWrite(`UART_ADDR_RBR_THR, 8'(divisor));
		apbWrite(`UART_ADDR_DLM, 8'h00);
		apbWrite(`UART_ADDR_LCR, l);
	endtask

	// Drives one frame on sin, then two idle bit times
	task automatic sendFrame(input logic [7:0] d, input logic [7:0] l, input logic flipParity,
		input logic zeroStop, input logic brk);
		logic [11:0] f;
		int n;
		int i;
		n = chk.frameLen(l);
		f = chk.frameRef(d, l);
		if (flipParity)
			f[6 + int'(l[1:0])] = !f[6 + int'(l[1:0])];
		if (zeroStop)
		begin
			f[n - 1] = 1'b0;
			if (l[2])
				f[n - 2] = 1'b0;
		end
		if (brk)
			f = '0;
		@(posedge CLK);
		#1;
		for (i = 0; i < n; i++)
		begin
			sin = f[i];
			repeat (divisor * `UART_OVERSAMPLE) @(posedge CLK);
			#1;
		end
		sin = 1'b1;
		repeat (2 * divisor * `UART_OVERSAMPLE) @(posedge CLK);
	endtask

	initial
	begin
		logic [7:0] v;
		logic [7:0] lcrSet[5];
		logic [7:0] sent[$];
		int s;
		int k;
		lcrSet = '{8'h03, 8'h1B, 8'h0E, 8'h29, 8'h3C};
		repeat (3) @(posedge CLK);
		#1;
		iRST = 1'b0;

		checkRead("reset LSR", `UART_ADDR_LSR, 8'h60, 8'hff);
		checkRead("reset LCR", `UART_ADDR_LCR, 8'h00, 8'hff);
		checkRead("reset MCR", `UART_ADDR_MCR, 8'h00, 8'hff);
		checkRead("reset SCR", `UART_ADDR_SCR, 8'h00, 8'hff);

		randByte(v);
		apbWrite(`UART_ADDR_SCR, v);
		checkRead("SCR readback", `UART_ADDR_SCR, v, 8'hff);
		apbWrite(`UART_ADDR_LCR, 8'h80);
		randByte(v);
		apbWrite(`UART_ADDR_RBR_THR, v);
		checkRead("DLL readback", `UART_ADDR_RBR_THR, v, 8'hff);
		randByte(v);
		apbWrite(`UART_ADDR_DLM, v);
		checkRead("DLM readback", `UART_ADDR_DLM, v, 8'hff);
		// Break control stays off so sout remains idle
		randByte(v);
		v = v & 8'hBF;
		apbWrite(`UART_ADDR_LCR, v);
		checkRead("LCR readback", `UART_ADDR_LCR, v, 8'hff);
		apbWrite(`UART_ADDR_LCR, 8'h00);
		checkRead("offset 1 without DLAB", `UART_ADDR_DLM, 8'h00, 8'hff);

		for (s = 0; s < 5; s++)
		begin
			setDivisor(lcrSet[s]);
			for (k = 0; k < 3; k++)
			begin
				randByte(v);
				apbWrite(`UART_ADDR_RBR_THR, v);
			end
			waitTxDone();
		end
		checkRead("LSR after transmit", `UART_ADDR_LSR, 8'h60, 8'hff);

		setDivisor(8'h03);
		apbWrite(`UART_ADDR_MCR, 8'h10);
		sent.delete();
		for (k = 0; k < 4; k++)
		begin
			randByte(v);
			sent.push_back(v);
			apbWrite(`UART_ADDR_RBR_THR, v);
		end
		for (k = 0; k < 4; k++)
		begin
			waitLsr(8'h01);
			checkRead("loopback RBR", `UART_ADDR_RBR_THR, sent[k], 8'hff);
		end
		checkRead("loopback DR clear", `UART_ADDR_LSR, 8'h00, 8'h01);
		apbWrite(`UART_ADDR_MCR, 8'h00);
		waitLsr(8'h40);

		setDivisor(8'h1B);
		sendFrame(8'h5A, 8'h1B, 1'b1, 1'b0, 1'b0);
		checkRead("parity error LSR", `UART_ADDR_LSR,
			chk.lsrRef(1, 0, 1, 0, 0, 1, 1), 8'hff);
		checkRead("LSR after PE read", `UART_ADDR_LSR, 8'h61, 8'hff);
		checkRead("parity error RBR", `UART_ADDR_RBR_THR, 8'h5A, 8'hff);
		checkRead("LSR after pop", `UART_ADDR_LSR, 8'h60, 8'hff);
		sendFrame(8'h33, 8'h1B, 1'b0, 1'b1, 1'b0);
		checkRead("framing error LSR", `UART_ADDR_LSR,
			chk.lsrRef(1, 0, 0, 1, 0, 1, 1), 8'hff);
		checkRead("LSR after FE read", `UART_ADDR_LSR, 8'h61, 8'hff);
		checkRead("framing error RBR", `UART_ADDR_RBR_THR, 8'h33, 8'hff);
		checkRead("LSR after pop", `UART_ADDR_LSR, 8'h60, 8'hff);
		sendFrame(8'h00, 8'h1B, 1'b0, 1'b0, 1'b1);
		checkRead("break LSR", `UART_ADDR_LSR, chk.lsrRef(1, 0, 0, 1, 1, 1, 1), 8'hff);
		checkRead("LSR after BI read", `UART_ADDR_LSR, 8'h61, 8'hff);
		checkRead("break RBR", `UART_ADDR_RBR_THR, 8'h00, 8'hff);
		checkRead("LSR after pop", `UART_ADDR_LSR, 8'h60, 8'hff);

		// One frame more than the RX FIFO holds
		apbWrite(`UART_ADDR_LCR, 8'h03);
		sent.delete();
		for (k = 0; k < `UART_FIFO_DEPTH + 1; k++)
		begin
			randByte(v);
			sent.push_back(v);
			sendFrame(v, 8'h03, 1'b0, 1'b0, 1'b0);
		end
		checkRead("overrun LSR", `UART_ADDR_LSR, chk.lsrRef(1, 1, 0, 0, 0, 1, 1), 8'hff);
		for (k = 0; k < `UART_FIFO_DEPTH; k++)
			checkRead("overrun RBR", `UART_ADDR_RBR_THR, sent[k], 8'hff);
		checkRead("LSR after overrun reads", `UART_ADDR_LSR, 8'h60, 8'hff);

		repeat (4) @(posedge CLK);
		$display("Checks: %0d, errors: %0d, unmet read expectations: %0d",
			chk.checks, chk.errors, chk.pendingReads());
		if (chk.errors == 0 && chk.pendingReads() == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
